/* compile.f */
+incdir+tests
rtl/cachePkg.sv
rtl/memBusPkg.sv
rtl/cacheCfgRegs.sv
rtl/cacheTagArray.sv
rtl/cacheDataArray.sv
rtl/cacheRefill.sv
rtl/cacheCtrl.sv
rtl/cacheTop.sv
tests/cacheTb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := cacheTb
FILELIST  := compile.f
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tests/cacheTests.svh */
`ifndef CACHE_TESTS_SVH
`define CACHE_TESTS_SVH

task automatic resetState();
  int errs0;
  errs0 = errCnt;
  checkValue("ready_o", 64'(ready_o), 64'd1);
  checkValue("memReq_o", 64'(memReq_o), 64'd0);
  checkValue("dataOk_o", 64'(dataOk_o), 64'd0);
  finishTest("reset state", errs0);
endtask

// first word of the set 1 line misses and the rest hit
task automatic coldMiss();
  int errs0;
  int req0;
  errs0 = errCnt;
  req0  = reqCount;
  readCheck(32'h0000_1030);
  readCheck(32'h0000_1020);
  readCheck(32'h0000_1028);
  readCheck(32'h0000_1038);
  checkValue("memory requests", 64'(reqCount - req0), 64'd1);
  finishTest("cold miss", errs0);
endtask

task automatic repeatedHits();
  int          errs0;
  int          req0;
  logic [31:0] base;
  logic [63:0] got;
  errs0 = errCnt;
  req0  = reqCount;
  base  = 32'h0000_1020;
  // valid stays high while the address moves on at each accept
  for (int i = 0; i < 4; i++) begin
    valid_i = 1'b1;
    addr_i  = base + 32'(i * 8);
    while (!ready_o) begin
      @(negedge clk);
    end
    @(negedge clk);
  end
  valid_i = 1'b0;
  while (okData.size() < 4) begin
    @(posedge clk);
  end
  repeat (4) @(posedge clk);
  checkValue("dataOk_o pulses", 64'(okData.size()), 64'd4);
  for (int i = 0; i < 4; i++) begin
    got = okData.pop_front();
    checkValue("rdData_o", got, memWord(base + 32'(i * 8)));
  end
  okData.delete();
  checkValue("memory requests", 64'(reqCount - req0), 64'd0);
  @(negedge clk);
  finishTest("repeated hits", errs0);
endtask

// A, B and C share set 5
task automatic twoWays();
  int          errs0;
  int          req0;
  logic [31:0] addrs [6];
  int          expReq [6];
  errs0  = errCnt;
  req0   = reqCount;
  addrs  = '{32'h0001_00A0, 32'h0002_00A8, 32'h0001_00B0,
             32'h0003_00B8, 32'h0001_00A8, 32'h0002_00A0};
  // C replaces B as the older of the two
  expReq = '{1, 2, 2, 3, 3, 4};
  for (int i = 0; i < 6; i++) begin
    readCheck(addrs[i]);
    checkValue("memory requests", 64'(reqCount - req0), 64'(expReq[i]));
  end
  finishTest("two ways", errs0);
endtask

task automatic invalidateAll();
  int errs0;
  int req0;
  errs0 = errCnt;
  req0  = reqCount;
  readCheck(32'h0000_1038);
  checkValue("memory requests", 64'(reqCount - req0), 64'd0);
  writeCfg(1'b1, 1'b1);
  readCheck(32'h0000_1038);
  checkValue("memory requests", 64'(reqCount - req0), 64'd1);
  finishTest("invalidate", errs0);
endtask

task automatic disabledReads();
  int errs0;
  int req0;
  errs0 = errCnt;
  req0  = reqCount;
  writeCfg(1'b0, 1'b0);
  // line is still resident, so only the disable forces the miss path
  for (int i = 0; i < 3; i++) begin
    readCheck(32'h0000_1038);
    checkValue("memory requests", 64'(reqCount - req0), 64'(i + 1));
  end
  writeCfg(1'b1, 1'b0);
  finishTest("disabled", errs0);
endtask

`endif

/* tests/cacheTb.sv */
module cacheTb
  import cachePkg::*;
  import memBusPkg::*;
();

  localparam int ResetCycles   = 16;
  // reads issued over all tests
  localparam int NumAccesses   = 19;
  localparam int TimeoutCycles = ResetCycles + NumAccesses * 40;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        valid_i;
  logic [31:0] addr_i;
  logic        ready_o;
  logic        dataOk_o;
  logic [63:0] rdData_o;
  logic        memReq_o;
  logic [31:0] memAddr_o;
  logic        memBeatValid_i = 1'b0;
  logic        memLast_i = 1'b0;
  logic [63:0] memData_i = '0;
  logic        cfgWrite_i;
  logic        cfgEnable_i;
  logic        cfgInval_i;

  logic [31:0] lfsrQ = 32'd74070;
  logic        burstOn = 1'b0;
  int          beatNo = 0;
  int          waitCnt = 0;
  int          reqCount = 0;
  int          cycleCnt = 0;
  int          errCnt = 0;
  int          checkCnt = 0;
  int          testCnt = 0;
  logic [63:0] okData [$];

  always #5 clk = ~clk;

  cacheTop #(
    .NumSetsP (NumSets)
  ) i_cacheTop (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .addr_i         (addr_i),
    .ready_o        (ready_o),
    .dataOk_o       (dataOk_o),
    .rdData_o       (rdData_o),
    .memReq_o       (memReq_o),
    .memAddr_o      (memAddr_o),
    .memBeatValid_i (memBeatValid_i),
    .memLast_i      (memLast_i),
    .memData_i      (memData_i),
    .cfgWrite_i     (cfgWrite_i),
    .cfgEnable_i    (cfgEnable_i),
    .cfgInval_i     (cfgInval_i)
  );

  // galois step, taken once per bit
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
  endfunction

  // memory contents depend only on the byte address
  function automatic logic [63:0] memWord(input logic [31:0] byteAddr);
    return {byteAddr ^ 32'hC3A5_0F96, ~byteAddr};
  endfunction

  task automatic drawGap(output int gap);
    logic [1:0] bits;
    for (int b = 0; b < 2; b++) begin
      lfsrQ   = lfsrNext(lfsrQ);
      bits[b] = lfsrQ[0];
    end
    gap = {30'b0, bits};
  endtask

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    checkCnt++;
    assert (got === exp) else begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      errCnt++;
    end
  endtask

  // burst memory with a random gap before every beat
  always @(negedge clk) begin
    memBeatValid_i = 1'b0;
    memLast_i      = 1'b0;
    if (!memReq_o) begin
      burstOn = 1'b0;
    end else begin
      if (!burstOn) begin
        burstOn = 1'b1;
        beatNo  = 0;
        reqCount++;
        // burst address is the line of the pending read
        checkValue("memAddr_o", 64'(memAddr_o), 64'({addr_i[31:5], 5'b00000}));
        drawGap(waitCnt);
      end
      if (waitCnt > 0) begin
        waitCnt--;
      end else if (beatNo < BeatsPerLine) begin
        memBeatValid_i = 1'b1;
        memData_i      = memWord(memAddr_o + 32'(beatNo * 8));
        memLast_i      = (beatNo == BeatsPerLine - 1);
        beatNo++;
        drawGap(waitCnt);
      end
    end
  end

  // collects every returned word
  always @(negedge clk) begin
    if (dataOk_o) begin
      okData.push_back(rdData_o);
    end
  end

  always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= TimeoutCycles) begin
      $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic finishTest(input string name, input int errs0);
    testCnt++;
    if (errCnt == errs0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errCnt - errs0);
    end
  endtask

  // called and returns on a falling edge
  task automatic readWord(input logic [31:0] addr, output logic [63:0] data);
    valid_i = 1'b1;
    addr_i  = addr;
    while (!ready_o) begin
      @(negedge clk);
    end
    @(negedge clk);
    valid_i = 1'b0;
    while (okData.size() == 0) begin
      @(posedge clk);
    end
    data = okData.pop_front();
    @(negedge clk);
  endtask

  task automatic readCheck(input logic [31:0] addr);
    logic [63:0] got;
    readWord(addr, got);
    checkValue("rdData_o", got, memWord({addr[31:3], 3'b000}));
  endtask

  task automatic writeCfg(input logic en, input logic inval);
    cfgWrite_i  = 1'b1;
    cfgEnable_i = en;
    cfgInval_i  = inval;
    @(negedge clk);
    cfgWrite_i = 1'b0;
    cfgInval_i = 1'b0;
    // registered pulse lands one edge later
    repeat (2) @(negedge clk);
  endtask

  `include "cacheTests.svh"

  initial begin
    rst_n       = 1'b0;
    valid_i     = 1'b0;
    addr_i      = '0;
    cfgWrite_i  = 1'b0;
    cfgEnable_i = 1'b1;
    cfgInval_i  = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    resetState();
    coldMiss();
    repeatedHits();
    twoWays();
    invalidateAll();
    disabledReads();
    $display("tests %0d, checks %0d, errors %0d", testCnt, checkCnt, errCnt);
    if (errCnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* rtl/cacheTop.sv */
module cacheTop
  import cachePkg::*;
  import memBusPkg::*;
#(
  parameter int NumSetsP = NumSets
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    valid_i,
  input  logic [AddrWidth-1:0]    addr_i,
  output logic                    ready_o,
  output logic                    dataOk_o,
  output logic [XLen-1:0]         rdData_o,
  output logic                    memReq_o,
  output logic [MemAddrWidth-1:0] memAddr_o,
  input  logic                    memBeatValid_i,
  input  logic                    memLast_i,
  input  logic [MemDataWidth-1:0] memData_i,
  input  logic                    cfgWrite_i,
  input  logic                    cfgEnable_i,
  input  logic                    cfgInval_i
);

  logic                    cacheEn;
  logic                    invalPulse;
  logic                    lookup;
  logic                    hit;
  logic                    hitWay;
  logic                    victimWay;
  logic [XLen-1:0]         word;
  logic                    beatWe;
  logic [BeatCntWidth-1:0] beatIdx;
  logic [MemDataWidth-1:0] beatData;
  logic                    refillDone;
  cacheAddrU               reqAddr;
  logic                    refillStart;
  logic                    allocate;
  logic                    allocWay;
  logic [AddrWidth-1:0]    lineAddr;
  logic                    arrayWe;

  // burst starts at the line boundary
  assign lineAddr = {reqAddr.raw[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};
  // lines are only filled while the cache is on
  assign arrayWe  = beatWe && cacheEn;

  cacheCfgRegs i_cacheCfgRegs (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfgWrite_i   (cfgWrite_i),
    .cfgEnable_i  (cfgEnable_i),
    .cfgInval_i   (cfgInval_i),
    .cacheEn_o    (cacheEn),
    .invalPulse_o (invalPulse)
  );

  cacheCtrl i_cacheCtrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_i       (valid_i),
    .addr_i        (addr_i),
    .ready_o       (ready_o),
    .dataOk_o      (dataOk_o),
    .rdData_o      (rdData_o),
    .cacheEn_i     (cacheEn),
    .hit_i         (hit),
    .hitWay_i      (hitWay),
    .victimWay_i   (victimWay),
    .word_i        (word),
    .beatWe_i      (beatWe),
    .beatIdx_i     (beatIdx),
    .beatData_i    (beatData),
    .refillDone_i  (refillDone),
    .lookup_o      (lookup),
    .reqAddr_o     (reqAddr),
    .refillStart_o (refillStart),
    .allocate_o    (allocate),
    .allocWay_o    (allocWay)
  );

  cacheTagArray #(
    .NumSetsP (NumSetsP)
  ) i_cacheTagArray (
    .clk           (clk),
    .rst_n         (rst_n),
    .lookup_i      (lookup),
    .lookupIndex_i (addr_i[OffsetWidth +: IndexWidth]),
    .cmpTag_i      (reqAddr.f.tag),
    .hit_o         (hit),
    .hitWay_o      (hitWay),
    .victimWay_o   (victimWay),
    .allocate_i    (allocate),
    .allocWay_i    (allocWay),
    .allocIndex_i  (reqAddr.f.index),
    .allocTag_i    (reqAddr.f.tag),
    .inval_i       (invalPulse)
  );

  cacheDataArray #(
    .NumSetsP (NumSetsP)
  ) i_cacheDataArray (
    .clk         (clk),
    .rd_i        (lookup),
    .rdIndex_i   (addr_i[OffsetWidth +: IndexWidth]),
    .rdWordSel_i (reqAddr.f.wordSel),
    .rdWay_i     (allocWay),
    .beatWe_i    (arrayWe),
    .wrWay_i     (allocWay),
    .wrIndex_i   (reqAddr.f.index),
    .beatIdx_i   (beatIdx),
    .beatData_i  (beatData),
    .word_o      (word)
  );

  cacheRefill i_cacheRefill (
    .clk            (clk),
    .rst_n          (rst_n),
    .refillStart_i  (refillStart),
    .lineAddr_i     (lineAddr),
    .memReq_o       (memReq_o),
    .memAddr_o      (memAddr_o),
    .memBeatValid_i (memBeatValid_i),
    .memLast_i      (memLast_i),
    .memData_i      (memData_i),
    .beatWe_o       (beatWe),
    .beatIdx_o      (beatIdx),
    .beatData_o     (beatData),
    .refillDone_o   (refillDone)
  );

endmodule

/* rtl/cacheCtrl.sv */
module cacheCtrl
  import cachePkg::*;
  import memBusPkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    valid_i,
  input  logic [AddrWidth-1:0]    addr_i,
  output logic                    ready_o,
  output logic                    dataOk_o,
  output logic [XLen-1:0]         rdData_o,
  input  logic                    cacheEn_i,
  input  logic                    hit_i,
  input  logic                    hitWay_i,
  input  logic                    victimWay_i,
  input  logic [XLen-1:0]         word_i,
  input  logic                    beatWe_i,
  input  logic [BeatCntWidth-1:0] beatIdx_i,
  input  logic [MemDataWidth-1:0] beatData_i,
  input  logic                    refillDone_i,
  output logic                    lookup_o,
  output cacheAddrU               reqAddr_o,
  output logic                    refillStart_o,
  output logic                    allocate_o,
  output logic                    allocWay_o
);

  localparam logic [1:0] StIdle    = 2'd0;
  localparam logic [1:0] StCompare = 2'd1;
  localparam logic [1:0] StRefill  = 2'd2;
  localparam logic [1:0] StRespond = 2'd3;

  logic [1:0]      stateQ;
  logic [1:0]      stateD;
  cacheAddrU       reqQ;
  logic            hitEff;
  logic            accept;
  logic            okQ;
  logic            allocWayQ;
  logic [XLen-1:0] rdDataQ;

  // a disabled cache never hits
  assign hitEff        = hit_i && cacheEn_i;
  assign ready_o       = (stateQ == StIdle) || ((stateQ == StCompare) && hitEff);
  assign accept        = valid_i && ready_o;
  assign lookup_o      = accept;
  assign refillStart_o = (stateQ == StCompare) && !hitEff;
  assign allocate_o    = (stateQ == StRespond) && cacheEn_i;
  // hit way steers the read during compare, victim way the fill afterwards
  assign allocWay_o    = (stateQ == StCompare) ? hitWay_i : allocWayQ;
  assign reqAddr_o     = reqQ;
  assign dataOk_o      = okQ;
  assign rdData_o      = rdDataQ;

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      StIdle: begin
        if (accept) begin
          stateD = StCompare;
        end
      end
      StCompare: begin
        if (!hitEff) begin
          stateD = StRefill;
        end else if (!accept) begin
          stateD = StIdle;
        end
      end
      StRefill: begin
        if (refillDone_i) begin
          stateD = StRespond;
        end
      end
      default: begin
        stateD = StIdle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= StIdle;
      okQ    <= 1'b0;
    end else begin
      stateQ <= stateD;
      okQ    <= ((stateQ == StCompare) && hitEff) || ((stateQ == StRefill) && refillDone_i);
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ.raw <= addr_i;
    end
    if (refillStart_o) begin
      allocWayQ <= victimWay_i;
    end
    // miss word is taken straight off the bus as its beat goes by
    if ((stateQ == StCompare) && hitEff) begin
      rdDataQ <= word_i;
    end else if ((stateQ == StRefill) && beatWe_i && (beatIdx_i == reqQ.f.wordSel)) begin
      rdDataQ <= beatData_i;
    end
  end

endmodule

/* rtl/cacheRefill.sv */
module cacheRefill
  import memBusPkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    refillStart_i,
  input  logic [MemAddrWidth-1:0] lineAddr_i,
  output logic                    memReq_o,
  output logic [MemAddrWidth-1:0] memAddr_o,
  input  logic                    memBeatValid_i,
  input  logic                    memLast_i,
  input  logic [MemDataWidth-1:0] memData_i,
  output logic                    beatWe_o,
  output logic [BeatCntWidth-1:0] beatIdx_o,
  output logic [MemDataWidth-1:0] beatData_o,
  output logic                    refillDone_o
);

  logic                    busyQ;
  logic [BeatCntWidth-1:0] beatCntQ;
  logic [MemAddrWidth-1:0] lineAddrQ;
  logic                    beatTake;

  // beats only count while a burst is open
  assign beatTake = busyQ && memBeatValid_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busyQ    <= 1'b0;
      beatCntQ <= '0;
    end else if (refillStart_i) begin
      busyQ    <= 1'b1;
      beatCntQ <= '0;
    end else if (beatTake) begin
      beatCntQ <= beatCntQ + 1'b1;
      if (memLast_i) begin
        busyQ <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (refillStart_i) begin
      lineAddrQ <= lineAddr_i;
    end
  end

  assign memReq_o     = busyQ;
  assign memAddr_o    = lineAddrQ;
  assign beatWe_o     = beatTake;
  assign beatIdx_o    = beatCntQ;
  assign beatData_o   = memData_i;
  // flags the closing beat of the burst
  assign refillDone_o = beatTake && memLast_i;

endmodule

/* rtl/cacheDataArray.sv */
module cacheDataArray
  import cachePkg::*;
  import memBusPkg::*;
#(
  parameter int  NumSetsP = 64,
  localparam int SetIdxW  = $clog2(NumSetsP)
) (
  input  logic                    clk,
  input  logic                    rd_i,
  input  logic [SetIdxW-1:0]      rdIndex_i,
  input  logic [BeatCntWidth-1:0] rdWordSel_i,
  input  logic                    rdWay_i,
  input  logic                    beatWe_i,
  input  logic                    wrWay_i,
  input  logic [SetIdxW-1:0]      wrIndex_i,
  input  logic [BeatCntWidth-1:0] beatIdx_i,
  input  logic [XLen-1:0]         beatData_i,
  output logic [XLen-1:0]         word_o
);

  // one word per beat, four per line
  logic [XLen-1:0] dataMem [NumWays][NumSetsP][BeatsPerLine];
  logic [XLen-1:0] lineQ [NumWays][BeatsPerLine];

  always_ff @(posedge clk) begin
    if (beatWe_i) begin
      dataMem[wrWay_i][wrIndex_i][beatIdx_i] <= beatData_i;
    end
  end

  // whole set is read, way is not known yet
  always_ff @(posedge clk) begin
    if (rd_i) begin
      for (int w = 0; w < NumWays; w++) begin
        for (int b = 0; b < BeatsPerLine; b++) begin
          lineQ[w][b] <= dataMem[w][rdIndex_i][b];
        end
      end
    end
  end

  // hit way picks the line, word select the beat
  assign word_o = lineQ[rdWay_i][rdWordSel_i];

endmodule

/* rtl/cacheTagArray.sv */
module cacheTagArray
  import cachePkg::*;
#(
  parameter int  NumSetsP = 64,
  localparam int SetIdxW  = $clog2(NumSetsP)
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                lookup_i,
  input  logic [SetIdxW-1:0]  lookupIndex_i,
  input  logic [TagWidth-1:0] cmpTag_i,
  output logic                hit_o,
  output logic                hitWay_o,
  output logic                victimWay_o,
  input  logic                allocate_i,
  input  logic                allocWay_i,
  input  logic [SetIdxW-1:0]  allocIndex_i,
  input  logic [TagWidth-1:0] allocTag_i,
  input  logic                inval_i
);

  logic [TagWidth-1:0]              tagMem [NumWays][NumSetsP];
  logic [NumWays-1:0][NumSetsP-1:0] validQ;
  // per set, the way to replace next
  logic [NumSetsP-1:0]              lruQ;

  logic [TagWidth-1:0] rdTagQ [NumWays];
  logic [NumWays-1:0]  rdValidQ;
  logic [SetIdxW-1:0]  lookIdxQ;
  logic                lookupQ;
  logic [NumWays-1:0]  wayMatch;

  always_ff @(posedge clk) begin
    if (allocate_i) begin
      tagMem[allocWay_i][allocIndex_i] <= allocTag_i;
    end
  end

  // both ways of the set are read on lookup
  always_ff @(posedge clk) begin
    if (lookup_i) begin
      for (int w = 0; w < NumWays; w++) begin
        rdTagQ[w]   <= tagMem[w][lookupIndex_i];
        rdValidQ[w] <= validQ[w][lookupIndex_i];
      end
      lookIdxQ <= lookupIndex_i;
    end
  end

  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      wayMatch[w] = rdValidQ[w] && (rdTagQ[w] == cmpTag_i);
    end
  end

  // compare only counts in the cycle right after a lookup
  assign hit_o       = lookupQ && (|wayMatch);
  assign hitWay_o    = wayMatch[1];
  assign victimWay_o = lruQ[allocIndex_i];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ  <= '0;
      lruQ    <= '0;
      lookupQ <= 1'b0;
    end else begin
      lookupQ <= lookup_i;
      if (inval_i) begin
        validQ <= '0;
      end else if (allocate_i) begin
        validQ[allocWay_i][allocIndex_i] <= 1'b1;
      end
      // the way just used becomes most recent
      if (allocate_i) begin
        lruQ[allocIndex_i] <= ~allocWay_i;
      end else if (hit_o) begin
        lruQ[lookIdxQ] <= ~hitWay_o;
      end
    end
  end

endmodule

/* rtl/cacheCfgRegs.sv */
module cacheCfgRegs (
  input  logic clk,
  input  logic rst_n,
  input  logic cfgWrite_i,
  input  logic cfgEnable_i,
  input  logic cfgInval_i,
  output logic cacheEn_o,
  output logic invalPulse_o
);

  logic enQ;
  logic invalQ;

  // cache comes up enabled
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enQ    <= 1'b1;
      invalQ <= 1'b0;
    end else begin
      // invalidate is a strobe, only live for the cycle after the write
      invalQ <= cfgWrite_i && cfgInval_i;
      if (cfgWrite_i) begin
        enQ <= cfgEnable_i;
      end
    end
  end

  assign cacheEn_o    = enQ;
  assign invalPulse_o = invalQ;

endmodule

/* rtl/memBusPkg.sv */
package memBusPkg;

  localparam int MemAddrWidth = 32;
  localparam int MemDataWidth = 64;
  // one line comes back as four data beats
  localparam int BeatsPerLine = 4;
  localparam int BeatCntWidth = 2;

endpackage

/* rtl/cachePkg.sv */
package cachePkg;

  localparam int AddrWidth   = 32;
  // width of one data word of the core
  localparam int XLen        = 64;
  localparam int TagWidth    = 21;
  localparam int IndexWidth  = 6;
  localparam int OffsetWidth = 5;
  localparam int NumSets     = 64;
  localparam int NumWays     = 2;

  // request address, read raw or split into tag, set and line offset
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    struct packed {
      logic [TagWidth-1:0]   tag;
      logic [IndexWidth-1:0] index;
      // which 64-bit word of the line
      logic [1:0]            wordSel;
      logic [2:0]            byteOff;
    } f;
  } cacheAddrU;

endpackage
